//--- sim.f
source/lq_pkg.sv
source/count_ones.sv
source/lq_ctrl.sv
source/lq_entry_array.sv
source/lq_commit_select.sv
source/load_queue_top.sv
tests/lq_checker.sv
tests/tb_load_queue.sv

//--- tests/tb_load_queue.sv
`timescale 1ns/100ps
`default_nettype none

module tb_load_queue import lq_pkg::*;;

    localparam int CLK_PERIOD      = 100;
    localparam int DIRECTED_CYCLES = 45;
    localparam int SOAK_CYCLES     = 300;
    localparam int TOTAL_CYCLES    = DIRECTED_CYCLES + SOAK_CYCLES + 3;

    logic                    clk;
    logic                    rst_n;
    logic                    flush;
    logic [LQ_ENQ_PORTS-1:0] enq_req;
    lq_enq_t                 enq_data [LQ_ENQ_PORTS];
    logic                    can_enq;
    lq_idx_t                 alloc_idx [LQ_ENQ_PORTS];
    lq_wb_t                  wb;
    logic [LQ_DEQ_PORTS-1:0] can_deq;
    lq_deq_t                 deq_data [LQ_DEQ_PORTS];
    logic [LQ_DEQ_PORTS-1:0] deq_req;

    // reference model with the oldest entry at the front
    lq_deq_t model_q [$];
    logic    model_fin [LQ_DEPTH];
    int      model_head;

    load_queue_top u_dut (
        .clk         (clk),
        .i_rst_n     (rst_n),
        .i_flush     (flush),
        .i_enq_req   (enq_req),
        .i_enq_data  (enq_data),
        .o_can_enq   (can_enq),
        .o_alloc_idx (alloc_idx),
        .i_wb        (wb),
        .o_can_deq   (can_deq),
        .o_deq_data  (deq_data),
        .i_deq_req   (deq_req)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * TOTAL_CYCLES * 2);
        $display("watchdog expired, tests did not finish within %0d cycles", TOTAL_CYCLES * 2);
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "first mismatch ends the run");
        end
    endtask

    // ********************
    // model helpers
    // ********************
    task automatic model_clear();
        model_q.delete();
        model_head = 0;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            model_fin[i] = 1'b0;
        end
    endtask

    function automatic int model_tail();
        return (model_head + model_q.size()) % LQ_DEPTH;
    endfunction

    // finished prefix over the two oldest entries
    function automatic logic [1:0] expect_can_deq();
        logic [1:0] e;
        e = 2'b00;
        if (model_q.size() >= 1 && model_fin[model_head]) begin
            e[0] = 1'b1;
            if (model_q.size() >= 2 && model_fin[(model_head + 1) % LQ_DEPTH]) begin
                e[1] = 1'b1;
            end
        end
        return e;
    endfunction

    function automatic lq_wb_t make_wb(input int idx);
        lq_wb_t w;
        w.vld    = 1'b1;
        w.lq_idx = LQ_IDX_W'(idx);
        w.paddr  = $urandom;
        return w;
    endfunction

    task automatic idle_inputs();
        enq_req = '0;
        deq_req = '0;
        wb      = '0;
        flush   = 1'b0;
        for (int p = 0; p < LQ_ENQ_PORTS; p++) begin
            enq_data[p] = '0;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        idle_inputs();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        model_clear();
    endtask

    // drive one cycle from a falling edge, check outputs, then predict the edge
    task automatic run_cycle(input logic [3:0] req, input logic [1:0] dreq,
                             input lq_wb_t w, input logic fl);
        logic [1:0] exp_deq;
        logic       exp_enq;
        int         k;
        int         pos;
        int         tail;
        lq_deq_t    item;
        enq_req = req;
        deq_req = dreq;
        wb      = w;
        flush   = fl;
        for (int p = 0; p < LQ_ENQ_PORTS; p++) begin
            enq_data[p].rob_idx = ROB_IDX_W'($urandom);
            enq_data[p].size    = lq_size_e'($urandom % 4);
        end
        #10;
        exp_enq = ($countones(req) <= LQ_DEPTH - model_q.size());
        exp_deq = expect_can_deq();
        check(can_enq, exp_enq, "o_can_enq");
        check(can_deq, exp_deq, "o_can_deq");
        for (int s = 0; s < LQ_DEQ_PORTS; s++) begin
            if (exp_deq[s]) begin
                check(deq_data[s], model_q[s], $sformatf("o_deq_data[%0d]", s));
            end else begin
                check(deq_data[s], '0, $sformatf("o_deq_data[%0d] of a blocked slot", s));
            end
        end
        tail = model_tail();
        k = 0;
        if (exp_enq) begin
            for (int p = 0; p < LQ_ENQ_PORTS; p++) begin
                if (req[p]) begin
                    check(alloc_idx[p], (tail + k) % LQ_DEPTH, $sformatf("o_alloc_idx[%0d]", p));
                    k++;
                end
            end
        end
        if (fl) begin
            model_clear();
        end else begin
            // writeback only lands on allocated entries
            if (w.vld) begin
                pos = (int'(w.lq_idx) - model_head + LQ_DEPTH) % LQ_DEPTH;
                if (pos < model_q.size()) begin
                    model_q[pos].paddr  = w.paddr;
                    model_fin[w.lq_idx] = 1'b1;
                end
            end
            for (int s = 0; s < LQ_DEQ_PORTS; s++) begin
                if (dreq[s] && exp_deq[s]) begin
                    model_fin[model_head] = 1'b0;
                    void'(model_q.pop_front());
                    model_head = (model_head + 1) % LQ_DEPTH;
                end
            end
            if (exp_enq) begin
                for (int p = 0; p < LQ_ENQ_PORTS; p++) begin
                    if (req[p]) begin
                        item.rob_idx = enq_data[p].rob_idx;
                        item.size    = enq_data[p].size;
                        item.paddr   = '0;
                        model_fin[model_tail()] = 1'b0;
                        model_q.push_back(item);
                    end
                end
            end
        end
        @(negedge clk);
    endtask

    // ********************
    // directed tests
    // ********************
    task automatic test_compact_alloc();
        apply_reset();
        run_cycle(4'b0101, 2'b00, '0, 1'b0);
        run_cycle(4'b1111, 2'b00, '0, 1'b0);
        run_cycle(4'b1000, 2'b00, '0, 1'b0);
        check(can_deq, 2'b00, "o_can_deq with nothing written back");
    endtask

    task automatic test_full_refuse();
        apply_reset();
        repeat (4) run_cycle(4'b1111, 2'b00, '0, 1'b0);
        run_cycle(4'b0001, 2'b00, '0, 1'b0);
        run_cycle(4'b0000, 2'b00, make_wb(0), 1'b0);
        // slot freed this cycle is not visible to the group yet
        run_cycle(4'b0010, 2'b01, '0, 1'b0);
        run_cycle(4'b0011, 2'b00, '0, 1'b0);
        run_cycle(4'b0100, 2'b00, '0, 1'b0);
    endtask

    task automatic test_ooo_writeback();
        apply_reset();
        run_cycle(4'b0111, 2'b00, '0, 1'b0);
        run_cycle(4'b0000, 2'b00, make_wb(2), 1'b0);
        run_cycle(4'b0000, 2'b00, make_wb(1), 1'b0);
        check(can_deq, 2'b00, "o_can_deq with entry 0 pending");
        run_cycle(4'b0000, 2'b00, make_wb(0), 1'b0);
        check(can_deq, 2'b11, "o_can_deq with entries 0 and 1 finished");
        run_cycle(4'b0000, 2'b11, '0, 1'b0);
        check(can_deq, 2'b01, "o_can_deq with entry 2 alone");
    endtask

    // continues from the state left by test_ooo_writeback
    task automatic test_wb_empty();
        run_cycle(4'b0000, 2'b00, make_wb(9), 1'b0);
        run_cycle(4'b0000, 2'b00, make_wb(3), 1'b0);
        run_cycle(4'b0001, 2'b00, '0, 1'b0);
        run_cycle(4'b0000, 2'b00, '0, 1'b0);
        check(can_deq, 2'b01, "o_can_deq after writes to empty slots");
    endtask

    task automatic test_flush();
        apply_reset();
        run_cycle(4'b1111, 2'b00, '0, 1'b0);
        run_cycle(4'b0011, 2'b00, make_wb(0), 1'b0);
        run_cycle(4'b0000, 2'b00, make_wb(1), 1'b0);
        run_cycle(4'b1111, 2'b11, make_wb(2), 1'b1);
        check(can_deq, 2'b00, "o_can_deq after flush");
        check(can_enq, 1'b1, "o_can_enq after flush");
        run_cycle(4'b0001, 2'b00, '0, 1'b0);
    endtask

    task automatic test_random_soak();
        logic [3:0] req;
        logic [1:0] dreq;
        lq_wb_t     w;
        int         pending [$];
        apply_reset();
        for (int c = 0; c < SOAK_CYCLES; c++) begin
            req = 4'($urandom) & 4'($urandom);
            case ($urandom % 3)
                0: dreq = 2'b00;
                1: dreq = 2'b01;
                default: dreq = 2'b11;
            endcase
            pending.delete();
            for (int i = 0; i < model_q.size(); i++) begin
                if (!model_fin[(model_head + i) % LQ_DEPTH]) begin
                    pending.push_back((model_head + i) % LQ_DEPTH);
                end
            end
            w = '0;
            if (pending.size() > 0 && ($urandom % 4) != 0) begin
                w = make_wb(pending[$urandom % pending.size()]);
            end else if (($urandom % 8) == 0) begin
                // any slot including empty ones
                w = make_wb($urandom % LQ_DEPTH);
            end
            run_cycle(req, dreq, w, 1'b0);
        end
    endtask

    initial begin
        void'($urandom(11));
        rst_n = 1'b0;
        idle_inputs();
        model_clear();
        test_compact_alloc();
        test_full_refuse();
        test_ooo_writeback();
        test_wb_empty();
        test_flush();
        test_random_soak();
        if (u_dut.u_ctrl.u_checker.fail_count != 0) begin
            $display("lq_checker reported %0d assertion failures",
                     u_dut.u_ctrl.u_checker.fail_count);
            $display("TB FAILED");
            $fatal(1, "assertion failures");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tests/lq_checker.sv
`timescale 1ns/100ps
`default_nettype none

module lq_checker import lq_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    i_rst_n,
    input  wire logic                    i_flush,
    input  wire logic [LQ_DEQ_PORTS-1:0] i_can_deq,
    input  wire lq_cnt_t                 i_occupancy
);

    // read by the testbench at the end of the run
    int fail_count = 0;

    // ********************
    // occupancy
    // ********************
    a_occ_bound: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_occupancy <= LQ_CNT_W'(LQ_DEPTH))
    else begin
        fail_count = fail_count + 1;
        $error("occupancy %0d above queue depth", i_occupancy);
    end

    // flush empties the queue in one cycle
    a_flush_empty: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_flush |=> (i_occupancy == '0))
    else begin
        fail_count = fail_count + 1;
        $error("occupancy not zero after flush");
    end

    // ********************
    // commit window
    // ********************
    a_deq_prefix: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_can_deq[1] && !i_can_deq[0]))
    else begin
        fail_count = fail_count + 1;
        $error("can_deq %b is not a prefix", i_can_deq);
    end

endmodule

bind lq_ctrl lq_checker u_checker (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_flush     (i_flush),
    .i_can_deq   (i_can_deq),
    .i_occupancy (occupancy)
);

`default_nettype wire

//--- source/load_queue_top.sv
`timescale 1ns/100ps
`default_nettype none

module load_queue_top import lq_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    i_rst_n,
    input  wire logic                    i_flush,
    // dispatch side
    input  wire logic [LQ_ENQ_PORTS-1:0] i_enq_req,
    input  wire lq_enq_t                 i_enq_data [LQ_ENQ_PORTS],
    output logic                         o_can_enq,
    output lq_idx_t                      o_alloc_idx [LQ_ENQ_PORTS],
    // load pipeline writeback
    input  wire lq_wb_t                  i_wb,
    // commit side
    output logic      [LQ_DEQ_PORTS-1:0] o_can_deq,
    output lq_deq_t                      o_deq_data [LQ_DEQ_PORTS],
    input  wire logic [LQ_DEQ_PORTS-1:0] i_deq_req
);

    logic [LQ_ENQ_PORTS-1:0] alloc_we;
    lq_idx_t                 head_idx;
    logic [2:0]              deq_num;
    lq_state_e               head_state [LQ_DEQ_PORTS];
    lq_deq_t                 head_entry [LQ_DEQ_PORTS];

    // ********************
    // pointers and counts
    // ********************
    lq_ctrl u_ctrl (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_flush     (i_flush),
        .i_enq_req   (i_enq_req),
        .i_deq_req   (i_deq_req),
        .i_can_deq   (o_can_deq),
        .o_can_enq   (o_can_enq),
        .o_alloc_we  (alloc_we),
        .o_alloc_idx (o_alloc_idx),
        .o_head_idx  (head_idx),
        .o_deq_num   (deq_num)
    );

    // ********************
    // storage
    // ********************
    lq_entry_array u_entries (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_flush      (i_flush),
        .i_alloc_we   (alloc_we),
        .i_alloc_idx  (o_alloc_idx),
        .i_enq_data   (i_enq_data),
        .i_wb         (i_wb),
        .i_head_idx   (head_idx),
        .i_deq_num    (deq_num),
        .o_head_state (head_state),
        .o_head_entry (head_entry)
    );

    // commit window over the two oldest entries
    lq_commit_select u_commit (
        .i_head_state (head_state),
        .i_head_entry (head_entry),
        .o_can_deq    (o_can_deq),
        .o_deq_data   (o_deq_data)
    );

endmodule

`default_nettype wire

//--- source/lq_commit_select.sv
`timescale 1ns/100ps
`default_nettype none

module lq_commit_select import lq_pkg::*; (
    input  wire lq_state_e               i_head_state [LQ_DEQ_PORTS],
    input  wire lq_deq_t                 i_head_entry [LQ_DEQ_PORTS],
    output logic [LQ_DEQ_PORTS-1:0]      o_can_deq,
    output lq_deq_t                      o_deq_data [LQ_DEQ_PORTS]
);

    logic [LQ_DEQ_PORTS-1:0] slot_done;

    always_comb begin
        for (int k = 0; k < LQ_DEQ_PORTS; k++) begin
            slot_done[k] = (i_head_state[k] == ST_FINISHED);
        end
    end

    // ********************
    // finished prefix
    // ********************
    // an unfinished older load blocks everything behind it
    always_comb begin
        logic run;
        run = 1'b1;
        for (int k = 0; k < LQ_DEQ_PORTS; k++) begin
            run          = run & slot_done[k];
            o_can_deq[k] = run;
        end
    end

    // data of slots that cannot leave is held at zero
    always_comb begin
        for (int k = 0; k < LQ_DEQ_PORTS; k++) begin
            if (o_can_deq[k]) begin
                o_deq_data[k] = i_head_entry[k];
            end else begin
                o_deq_data[k] = '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/lq_entry_array.sv
`timescale 1ns/100ps
`default_nettype none

module lq_entry_array import lq_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    i_rst_n,
    input  wire logic                    i_flush,
    input  wire logic [LQ_ENQ_PORTS-1:0] i_alloc_we,
    input  wire lq_idx_t                 i_alloc_idx [LQ_ENQ_PORTS],
    input  wire lq_enq_t                 i_enq_data [LQ_ENQ_PORTS],
    input  wire lq_wb_t                  i_wb,
    input  wire lq_idx_t                 i_head_idx,
    input  wire logic [2:0]              i_deq_num,
    output lq_state_e                    o_head_state [LQ_DEQ_PORTS],
    output lq_deq_t                      o_head_entry [LQ_DEQ_PORTS]
);

    lq_deq_t   entry_q [LQ_DEPTH];
    lq_state_e state_q [LQ_DEPTH];
    lq_idx_t   head_slot [LQ_DEQ_PORTS];
    logic      wb_hit;

    // head and head+1 wrap past the last entry
    always_comb begin
        for (int k = 0; k < LQ_DEQ_PORTS; k++) begin
            head_slot[k] = i_head_idx + LQ_IDX_W'(k);
        end
    end

    // writes to unallocated entries are dropped
    assign wb_hit = i_wb.vld && (state_q[i_wb.lq_idx] != ST_EMPTY);

    // ********************
    // payload
    // ********************
    always_ff @(posedge clk) begin
        for (int p = 0; p < LQ_ENQ_PORTS; p++) begin
            if (i_alloc_we[p]) begin
                entry_q[i_alloc_idx[p]].rob_idx <= i_enq_data[p].rob_idx;
                entry_q[i_alloc_idx[p]].size    <= i_enq_data[p].size;
            end
        end
        if (wb_hit) begin
            entry_q[i_wb.lq_idx].paddr <= i_wb.paddr;
        end
    end

    // ********************
    // entry state
    // ********************
    // allocation only ever targets empty slots, so it cannot collide
    // with a writeback or a dequeue in the same cycle
    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            for (int e = 0; e < LQ_DEPTH; e++) begin
                state_q[e] <= ST_EMPTY;
            end
        end else begin
            if (wb_hit) begin
                state_q[i_wb.lq_idx] <= ST_FINISHED;
            end
            for (int p = 0; p < LQ_ENQ_PORTS; p++) begin
                if (i_alloc_we[p]) begin
                    state_q[i_alloc_idx[p]] <= ST_ISSUED;
                end
            end
            // freeing comes last so it wins over a late writeback
            for (int k = 0; k < LQ_DEQ_PORTS; k++) begin
                if (i_deq_num > 3'(k)) begin
                    state_q[head_slot[k]] <= ST_EMPTY;
                end
            end
        end
    end

    // ********************
    // head read
    // ********************
    always_comb begin
        for (int k = 0; k < LQ_DEQ_PORTS; k++) begin
            o_head_state[k] = state_q[head_slot[k]];
            o_head_entry[k] = entry_q[head_slot[k]];
        end
    end

endmodule

`default_nettype wire

//--- source/lq_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module lq_ctrl import lq_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    i_rst_n,
    input  wire logic                    i_flush,
    input  wire logic [LQ_ENQ_PORTS-1:0] i_enq_req,
    input  wire logic [LQ_DEQ_PORTS-1:0] i_deq_req,
    input  wire logic [LQ_DEQ_PORTS-1:0] i_can_deq,
    output logic                         o_can_enq,
    output logic      [LQ_ENQ_PORTS-1:0] o_alloc_we,
    output lq_idx_t                      o_alloc_idx [LQ_ENQ_PORTS],
    output lq_idx_t                      o_head_idx,
    output logic      [2:0]              o_deq_num
);

    lq_idx_t tail_idx;
    lq_idx_t head_idx;
    lq_cnt_t occupancy;
    lq_cnt_t free_cnt;

    logic [2:0]              enq_num;
    logic [2:0]              enq_acc;
    logic [2:0]              deq_num;
    logic [LQ_DEQ_PORTS-1:0] deq_acc;

    // ********************
    // request counting
    // ********************
    count_ones u_enq_count (
        .i_a   (i_enq_req),
        .o_sum (enq_num)
    );

    // only commit requests that the head can actually serve
    assign deq_acc = i_deq_req & i_can_deq;

    count_ones u_deq_count (
        .i_a   ({2'b00, deq_acc}),
        .o_sum (deq_num)
    );

    // free space from the registered count only,
    // so slots freed this cycle are not reused until the next one
    assign free_cnt  = LQ_CNT_W'(LQ_DEPTH) - occupancy;
    assign o_can_enq = ({2'b00, enq_num} <= free_cnt);

    // all or nothing
    assign enq_acc    = o_can_enq ? enq_num : 3'd0;
    assign o_alloc_we = o_can_enq ? i_enq_req : '0;

    // ********************
    // compacted indices
    // ********************
    // k-th set bit takes tail + k
    always_comb begin
        lq_idx_t offset;
        offset = '0;
        for (int p = 0; p < LQ_ENQ_PORTS; p++) begin
            o_alloc_idx[p] = tail_idx + offset;
            offset         = offset + LQ_IDX_W'(i_enq_req[p]);
        end
    end

    assign o_head_idx = head_idx;
    assign o_deq_num  = deq_num;

    // ********************
    // pointers
    // ********************
    // 4-bit pointers wrap modulo 16 by themselves
    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            tail_idx  <= '0;
            head_idx  <= '0;
            occupancy <= '0;
        end else begin
            tail_idx  <= tail_idx + LQ_IDX_W'(enq_acc);
            head_idx  <= head_idx + LQ_IDX_W'(deq_num);
            occupancy <= occupancy + LQ_CNT_W'(enq_acc) - LQ_CNT_W'(deq_num);
        end
    end

endmodule

`default_nettype wire

//--- source/count_ones.sv
`timescale 1ns/100ps
`default_nettype none

module count_ones (
    input  wire logic [3:0] i_a,
    output logic      [2:0] o_sum
);

    // ripple sum over the four request bits
    always_comb begin
        logic [2:0] acc;
        acc = 3'd0;
        for (int b = 0; b < 4; b++) begin
            acc = acc + {2'b00, i_a[b]};
        end
        o_sum = acc;
    end

endmodule

`default_nettype wire

//--- source/lq_pkg.sv
`default_nettype none

package lq_pkg;

    // ********************
    // sizes
    // ********************
    localparam int LQ_DEPTH     = 16;
    localparam int LQ_IDX_W     = 4;
    localparam int LQ_CNT_W     = 5;
    localparam int LQ_ENQ_PORTS = 4;
    localparam int LQ_DEQ_PORTS = 2;
    localparam int ROB_IDX_W    = 6;
    localparam int PADDR_W      = 32;

    typedef logic [LQ_IDX_W-1:0] lq_idx_t;
    typedef logic [LQ_CNT_W-1:0] lq_cnt_t;

    // ********************
    // enums
    // ********************
    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_HALF  = 2'd1,
        SZ_WORD  = 2'd2,
        SZ_DWORD = 2'd3
    } lq_size_e;

    // issued means allocated with the address not back yet
    typedef enum logic [1:0] {
        ST_EMPTY    = 2'd0,
        ST_ISSUED   = 2'd1,
        ST_FINISHED = 2'd2
    } lq_state_e;

    // ********************
    // structs
    // ********************
    typedef struct packed {
        logic [ROB_IDX_W-1:0] rob_idx;
        lq_size_e             size;
    } lq_enq_t;

    typedef struct packed {
        logic                 vld;
        lq_idx_t              lq_idx;
        logic [PADDR_W-1:0]   paddr;
    } lq_wb_t;

    // one load leaving at commit
    typedef struct packed {
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [PADDR_W-1:0]   paddr;
        lq_size_e             size;
    } lq_deq_t;

endpackage

`default_nettype wire
